/* source/dcache_geom_pkg.sv */
`default_nettype none

package dcache_geom_pkg;

    ////////////////////
    // widths
    ////////////////////

    localparam int WORD_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int LINE_W     = 512;
    localparam int LINE_BYTES = LINE_W / 8;

    // the line index sits just above the 64-byte offset.
    localparam int INDEX_W    = 4;
    localparam int INDEX_LSB  = 6;

    localparam int LINE_COUNT = 2 ** INDEX_W;

    ////////////////////
    // types
    ////////////////////

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [LINE_W-1:0]     line_data_t;
    typedef logic [LINE_BYTES-1:0] line_be_t;
    typedef logic [INDEX_W-1:0]    index_t;

endpackage

`default_nettype wire

/* source/dcache_store_pkg.sv */
`default_nettype none

package dcache_store_pkg;

    ////////////////////
    // store write types
    ////////////////////

    // a write type is the byte-lane mask of the store before any shift.
    typedef logic [3:0] wrt_type_t;

    localparam wrt_type_t WRT_BYTE = 4'b0001;
    localparam wrt_type_t WRT_HALF = 4'b0011;
    localparam wrt_type_t WRT_WORD = 4'b1111;

    ////////////////////
    // store queue
    ////////////////////

    localparam int STQ_DEPTH = 4;
    localparam int STQ_PTR_W = $clog2(STQ_DEPTH);
    localparam int STQ_CNT_W = STQ_PTR_W + 1;

    // what the request buffer currently holds.
    typedef enum logic [1:0] {
        ARB_IDLE   = 2'd0,
        ARB_STORE  = 2'd1,
        ARB_REFILL = 2'd2
    } arb_state_t;

endpackage

`default_nettype wire

/* source/store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         st_valid,
    input  wire dcache_geom_pkg::addr_t st_addr,
    input  wire dcache_geom_pkg::word_t st_data,
    input  wire dcache_store_pkg::wrt_type_t st_type,
    input  wire                         st_cacop,
    input  wire                         q_pop,
    output logic                        st_full,
    output logic                        q_empty,
    output dcache_geom_pkg::addr_t      q_addr,
    output dcache_geom_pkg::word_t      q_data,
    output dcache_store_pkg::wrt_type_t q_type,
    output logic                        q_cacop
);

    dcache_geom_pkg::addr_t      addr_mem  [dcache_store_pkg::STQ_DEPTH];
    dcache_geom_pkg::word_t      data_mem  [dcache_store_pkg::STQ_DEPTH];
    dcache_store_pkg::wrt_type_t type_mem  [dcache_store_pkg::STQ_DEPTH];
    logic                        cacop_mem [dcache_store_pkg::STQ_DEPTH];

    logic [dcache_store_pkg::STQ_PTR_W-1:0] wr_ptr;
    logic [dcache_store_pkg::STQ_PTR_W-1:0] rd_ptr;
    logic [dcache_store_pkg::STQ_CNT_W-1:0] count;

    logic push;
    logic pop;

    assign st_full = (count == dcache_store_pkg::STQ_CNT_W'(dcache_store_pkg::STQ_DEPTH));
    assign q_empty = (count == '0);

    // a push into a full queue is dropped, the driver is expected to hold off.
    assign push = st_valid & ~st_full;
    assign pop  = q_pop & ~q_empty;

    ////////////////////
    // entry storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr]  <= st_addr;
            data_mem[wr_ptr]  <= st_data;
            type_mem[wr_ptr]  <= st_type;
            cacop_mem[wr_ptr] <= st_cacop;
        end
    end

    assign q_addr  = addr_mem[rd_ptr];
    assign q_data  = data_mem[rd_ptr];
    assign q_type  = type_mem[rd_ptr];
    assign q_cacop = cacop_mem[rd_ptr];

    ////////////////////
    // pointers and count
    ////////////////////

    // the depth is a power of two, so the pointers wrap on their own.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/refill_store_arb.sv */
`timescale 1ns/1ps
`default_nettype none

module refill_store_arb (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              refill_valid,
    input  wire dcache_geom_pkg::addr_t      refill_addr,
    input  wire dcache_geom_pkg::line_data_t refill_line,
    input  wire                              q_empty,
    input  wire dcache_geom_pkg::addr_t      q_addr,
    input  wire dcache_geom_pkg::word_t      q_data,
    input  wire dcache_store_pkg::wrt_type_t q_type,
    input  wire                              q_cacop,
    output logic                             q_pop,
    output logic                             req_valid,
    output dcache_geom_pkg::addr_t           addr_rbuf,
    output dcache_geom_pkg::word_t           w_data_cpu,
    output dcache_geom_pkg::line_data_t      w_data_axi,
    output dcache_store_pkg::wrt_type_t      wrt_type,
    output logic                             cacop_en_rbuf,
    output logic                             wrt_data_sel
);

    dcache_store_pkg::arb_state_t state;
    dcache_store_pkg::arb_state_t state_nxt;

    ////////////////////
    // selection
    ////////////////////

    // a refill cannot be stalled, so it always takes the buffer.
    always_comb begin
        state_nxt = dcache_store_pkg::ARB_IDLE;
        if (refill_valid) begin
            state_nxt = dcache_store_pkg::ARB_REFILL;
        end else if (!q_empty) begin
            state_nxt = dcache_store_pkg::ARB_STORE;
        end
    end

    assign q_pop = (state_nxt == dcache_store_pkg::ARB_STORE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= dcache_store_pkg::ARB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // the buffer holds a write exactly when the state is not idle.
    assign req_valid    = (state != dcache_store_pkg::ARB_IDLE);
    assign wrt_data_sel = (state == dcache_store_pkg::ARB_STORE);

    ////////////////////
    // request buffer
    ////////////////////

    always_ff @(posedge clk) begin
        if (refill_valid) begin
            addr_rbuf     <= refill_addr;
            w_data_axi    <= refill_line;
            wrt_type      <= dcache_store_pkg::WRT_WORD;
            cacop_en_rbuf <= 1'b0;
        end else if (q_pop) begin
            addr_rbuf     <= q_addr;
            w_data_cpu    <= q_data;
            wrt_type      <= q_type;
            cacop_en_rbuf <= q_cacop;
        end
    end

endmodule

`default_nettype wire

/* source/mem_wrt_ctrl_d.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wrt_ctrl_d (
    input  wire dcache_geom_pkg::word_t      w_data_cpu,
    input  wire dcache_geom_pkg::line_data_t w_data_axi,
    input  wire dcache_geom_pkg::addr_t      addr_rbuf,
    input  wire dcache_store_pkg::wrt_type_t wrt_type,
    input  wire                              wrt_data_sel,
    input  wire                              cacop_en_rbuf,
    output dcache_geom_pkg::line_data_t      mem_din,
    output dcache_geom_pkg::line_be_t        mem_we,
    output dcache_store_pkg::wrt_type_t      axi_we
);

    ////////////////////
    // line data
    ////////////////////

    // the store word is replicated across the line, the enables pick the bytes.
    always_comb begin
        if (!wrt_data_sel) begin
            mem_din = w_data_axi;
        end else begin
            case (wrt_type)
                dcache_store_pkg::WRT_BYTE: mem_din = {64{w_data_cpu[7:0]}};
                dcache_store_pkg::WRT_HALF: mem_din = {32{w_data_cpu[15:0]}};
                dcache_store_pkg::WRT_WORD: mem_din = {16{w_data_cpu}};
                default:                    mem_din = '0;
            endcase
        end
    end

    ////////////////////
    // lane mask
    ////////////////////

    // cache ops ignore the byte offset. lanes shifted past bit 3 are dropped.
    always_comb begin
        if (cacop_en_rbuf) begin
            axi_we = wrt_type;
        end else begin
            case (addr_rbuf[1:0])
                2'd0: axi_we = wrt_type;
                2'd1: axi_we = {wrt_type[2:0], 1'b0};
                2'd2: axi_we = {wrt_type[1:0], 2'b00};
                2'd3: axi_we = {wrt_type[0], 3'b000};
                default: axi_we = wrt_type;
            endcase
        end
    end

    ////////////////////
    // line enable
    ////////////////////

    // address bits 5 to 2 pick which word of the line gets the lane mask.
    always_comb begin
        if (!wrt_data_sel) begin
            mem_we = '1;
        end else begin
            mem_we = dcache_geom_pkg::line_be_t'(axi_we) << {addr_rbuf[5:2], 2'b00};
        end
    end

endmodule

`default_nettype wire

/* source/data_line_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_line_ram (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              we_en,
    input  wire dcache_geom_pkg::index_t     wr_index,
    input  wire dcache_geom_pkg::line_data_t mem_din,
    input  wire dcache_geom_pkg::line_be_t   mem_we,
    input  wire                              rd_en,
    input  wire dcache_geom_pkg::index_t     rd_index,
    output dcache_geom_pkg::line_data_t      rd_line
);

    dcache_geom_pkg::line_data_t mem [dcache_geom_pkg::LINE_COUNT];

    // the read samples the array before this edge's write lands, so a
    // same-line write and read return the old contents.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < dcache_geom_pkg::LINE_COUNT; i++) begin
                mem[i] <= '0;
            end
            rd_line <= '0;
        end else begin
            if (we_en) begin
                for (int b = 0; b < dcache_geom_pkg::LINE_BYTES; b++) begin
                    if (mem_we[b]) begin
                        mem[wr_index][b*8 +: 8] <= mem_din[b*8 +: 8];
                    end
                end
            end
            if (rd_en) begin
                rd_line <= mem[rd_index];
            end
        end
    end

endmodule

`default_nettype wire

/* source/dcache_wr_path.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_wr_path (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              st_valid,
    input  wire dcache_geom_pkg::addr_t      st_addr,
    input  wire dcache_geom_pkg::word_t      st_data,
    input  wire dcache_store_pkg::wrt_type_t st_type,
    input  wire                              st_cacop,
    input  wire                              refill_valid,
    input  wire dcache_geom_pkg::addr_t      refill_addr,
    input  wire dcache_geom_pkg::line_data_t refill_line,
    input  wire                              rd_en,
    input  wire dcache_geom_pkg::index_t     rd_index,
    output logic                             st_full,
    output logic                             wr_idle,
    output dcache_geom_pkg::line_data_t      rd_line,
    output dcache_store_pkg::wrt_type_t      axi_we
);

    logic                        q_empty;
    logic                        q_pop;
    dcache_geom_pkg::addr_t      q_addr;
    dcache_geom_pkg::word_t      q_data;
    dcache_store_pkg::wrt_type_t q_type;
    logic                        q_cacop;

    logic                        req_valid;
    dcache_geom_pkg::addr_t      addr_rbuf;
    dcache_geom_pkg::word_t      w_data_cpu;
    dcache_geom_pkg::line_data_t w_data_axi;
    dcache_store_pkg::wrt_type_t wrt_type;
    logic                        cacop_en_rbuf;
    logic                        wrt_data_sel;

    dcache_geom_pkg::line_data_t mem_din;
    dcache_geom_pkg::line_be_t   mem_we;

    assign wr_idle = q_empty & ~req_valid;

    store_queue u_store_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .st_valid (st_valid),
        .st_addr  (st_addr),
        .st_data  (st_data),
        .st_type  (st_type),
        .st_cacop (st_cacop),
        .q_pop    (q_pop),
        .st_full  (st_full),
        .q_empty  (q_empty),
        .q_addr   (q_addr),
        .q_data   (q_data),
        .q_type   (q_type),
        .q_cacop  (q_cacop)
    );

    refill_store_arb u_refill_store_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .refill_valid  (refill_valid),
        .refill_addr   (refill_addr),
        .refill_line   (refill_line),
        .q_empty       (q_empty),
        .q_addr        (q_addr),
        .q_data        (q_data),
        .q_type        (q_type),
        .q_cacop       (q_cacop),
        .q_pop         (q_pop),
        .req_valid     (req_valid),
        .addr_rbuf     (addr_rbuf),
        .w_data_cpu    (w_data_cpu),
        .w_data_axi    (w_data_axi),
        .wrt_type      (wrt_type),
        .cacop_en_rbuf (cacop_en_rbuf),
        .wrt_data_sel  (wrt_data_sel)
    );

    mem_wrt_ctrl_d u_mem_wrt_ctrl_d (
        .w_data_cpu    (w_data_cpu),
        .w_data_axi    (w_data_axi),
        .addr_rbuf     (addr_rbuf),
        .wrt_type      (wrt_type),
        .wrt_data_sel  (wrt_data_sel),
        .cacop_en_rbuf (cacop_en_rbuf),
        .mem_din       (mem_din),
        .mem_we        (mem_we),
        .axi_we        (axi_we)
    );

    data_line_ram u_data_line_ram (
        .clk      (clk),
        .rst_n    (rst_n),
        .we_en    (req_valid),
        .wr_index (addr_rbuf[dcache_geom_pkg::INDEX_LSB +: dcache_geom_pkg::INDEX_W]),
        .mem_din  (mem_din),
        .mem_we   (mem_we),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_line  (rd_line)
    );

endmodule

`default_nettype wire

/* bench/dcache_wr_path_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_wr_path_sva (
    input wire clk,
    input wire rst_n,
    input wire st_valid,
    input wire st_full,
    input wire q_pop,
    input wire q_empty,
    input wire refill_valid,
    input wire req_valid
);

    int assert_fails;

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        st_full |-> !st_valid)
        else begin
            $error("store pushed while the queue is full");
            assert_fails++;
        end

    no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        q_empty |-> !q_pop)
        else begin
            $error("queue popped while empty");
            assert_fails++;
        end

    // a refill owns the request buffer in its cycle.
    pop_yields_to_refill: assert property (@(posedge clk) disable iff (!rst_n)
        refill_valid |-> !q_pop)
        else begin
            $error("queue popped in a refill cycle");
            assert_fails++;
        end

    idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !req_valid)
        else begin
            $error("request buffer valid right after reset");
            assert_fails++;
        end

endmodule

bind dcache_wr_path dcache_wr_path_sva u_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .st_valid     (st_valid),
    .st_full      (st_full),
    .q_pop        (q_pop),
    .q_empty      (q_empty),
    .refill_valid (refill_valid),
    .req_valid    (req_valid)
);

`default_nettype wire

/* bench/dcache_wr_path_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_wr_path_tb;

    // the directed tests need well under half of this.
    localparam int MAX_CYCLES = 4000;

    logic                        clk;
    logic                        rst_n;
    logic                        st_valid;
    dcache_geom_pkg::addr_t      st_addr;
    dcache_geom_pkg::word_t      st_data;
    dcache_store_pkg::wrt_type_t st_type;
    logic                        st_cacop;
    logic                        refill_valid;
    dcache_geom_pkg::addr_t      refill_addr;
    dcache_geom_pkg::line_data_t refill_line;
    logic                        rd_en;
    dcache_geom_pkg::index_t     rd_index;
    logic                        st_full;
    logic                        wr_idle;
    dcache_geom_pkg::line_data_t rd_line;
    dcache_store_pkg::wrt_type_t axi_we;

    dcache_geom_pkg::line_data_t model [dcache_geom_pkg::LINE_COUNT];
    logic [31:0] lfsr_state;
    int err_count;
    int pass_count;
    int fail_count;
    int cycle_count;

    dcache_wr_path dut (
        .clk (clk), .rst_n (rst_n), .st_valid (st_valid), .st_addr (st_addr),
        .st_data (st_data), .st_type (st_type), .st_cacop (st_cacop),
        .refill_valid (refill_valid), .refill_addr (refill_addr),
        .refill_line (refill_line), .rd_en (rd_en), .rd_index (rd_index),
        .st_full (st_full), .wr_idle (wr_idle), .rd_line (rd_line), .axi_we (axi_we)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the write path did not go idle within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////
    // stimulus source

    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // index in bits 9..6, word group in 5..2, byte offset in 1..0.
    function automatic dcache_geom_pkg::addr_t make_addr(input logic [3:0] idx,
                                                         input logic [3:0] grp,
                                                         input logic [1:0] off);
        logic [31:0] hi;
        hi = rand_bits(22);
        return {hi[21:0], idx, grp, off};
    endfunction

    ////////////////////
    // reference model

    function automatic logic [3:0] lane_mask(input logic [3:0] t, input logic [1:0] off,
                                             input logic cacop);
        logic [7:0] wide;
        wide = {4'b0000, t} << off;
        return cacop ? t : wide[3:0];
    endfunction

    function automatic void model_store(input dcache_geom_pkg::addr_t a,
                                        input dcache_geom_pkg::word_t d,
                                        input logic [3:0] t, input logic cacop);
        logic [3:0] mask;
        logic [7:0] bval;
        int         base;
        mask = lane_mask(t, a[1:0], cacop);
        base = a[5:2] * 32;
        for (int lane = 0; lane < 4; lane++) begin
            if (t == dcache_store_pkg::WRT_BYTE) bval = d[7:0];
            else if (t == dcache_store_pkg::WRT_HALF) bval = d[(lane % 2) * 8 +: 8];
            else if (t == dcache_store_pkg::WRT_WORD) bval = d[lane * 8 +: 8];
            else bval = 8'h00;
            if (mask[lane]) model[a[9:6]][base + lane * 8 +: 8] = bval;
        end
    endfunction

    ////////////////////
    // bus actions

    task automatic push_store(input logic [3:0] idx, input logic [3:0] grp,
                              input logic [1:0] off, input logic [3:0] t, input logic cacop);
        dcache_geom_pkg::addr_t a;
        dcache_geom_pkg::word_t d;
        a = make_addr(idx, grp, off);
        d = rand_bits(32);
        while (st_full) @(negedge clk);
        st_valid = 1'b1;
        st_addr  = a;
        st_data  = d;
        st_type  = t;
        st_cacop = cacop;
        @(negedge clk);
        st_valid = 1'b0;
        model_store(a, d, t, cacop);
    endtask

    // leaves refill_valid high, the caller ends the pulse.
    task automatic start_refill(input logic [3:0] idx);
        refill_addr  = make_addr(idx, 4'h0, 2'b00);
        for (int w = 0; w < 16; w++) refill_line[w*32 +: 32] = rand_bits(32);
        refill_valid = 1'b1;
        model[idx]   = refill_line;
    endtask

    task automatic wait_idle_and_check();
        while (!wr_idle) @(negedge clk);
        for (int i = 0; i < dcache_geom_pkg::LINE_COUNT; i++) begin
            rd_en    = 1'b1;
            rd_index = 4'(i);
            @(negedge clk);
            rd_en = 1'b0;
            if (rd_line !== model[i]) begin
                $display("FAILED rd_line line %0d expected %h actual %h", i, model[i], rd_line);
                err_count++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("%s: passed", name);
            pass_count++;
        end else begin
            $display("%s: failed with %0d errors", name, err_count - errs_before);
            fail_count++;
        end
    endtask

    ////////////////////
    // directed tests

    task automatic word_store_test();
        int e0;
        e0 = err_count;
        for (int n = 0; n < 8; n++) begin
            push_store(4'(rand_bits(4)), 4'(rand_bits(4)), 2'b00,
                       dcache_store_pkg::WRT_WORD, 1'b0);
        end
        wait_idle_and_check();
        report_test("word_store", e0);
    endtask

    task automatic partial_store_test();
        int e0;
        e0 = err_count;
        for (int off = 0; off < 4; off++) begin
            push_store(4'(rand_bits(4)), 4'(rand_bits(4)), 2'(off),
                       dcache_store_pkg::WRT_BYTE, 1'b0);
            push_store(4'(rand_bits(4)), 4'(rand_bits(4)), 2'(off),
                       dcache_store_pkg::WRT_HALF, 1'b0);
        end
        wait_idle_and_check();
        report_test("partial_store", e0);
    endtask

    task automatic refill_merge_test();
        int         e0;
        logic [3:0] idx;
        e0  = err_count;
        idx = 4'(rand_bits(4));
        start_refill(idx);
        @(negedge clk);
        refill_valid = 1'b0;
        push_store(idx, 4'h3, 2'b01, dcache_store_pkg::WRT_BYTE, 1'b0);
        push_store(idx, 4'h3, 2'b10, dcache_store_pkg::WRT_HALF, 1'b0);
        push_store(idx, 4'hc, 2'b00, dcache_store_pkg::WRT_WORD, 1'b0);
        wait_idle_and_check();
        report_test("refill_merge", e0);
    endtask

    task automatic cacop_test();
        int e0;
        e0 = err_count;
        push_store(4'h5, 4'h7, 2'b10, dcache_store_pkg::WRT_HALF, 1'b1);
        push_store(4'h9, 4'h1, 2'b11, dcache_store_pkg::WRT_BYTE, 1'b1);
        wait_idle_and_check();
        report_test("cacop_store", e0);
    endtask

    // the refill is held over the pushes so that the queue cannot drain.
    task automatic full_queue_test();
        int         e0;
        logic [3:0] idx;
        e0  = err_count;
        idx = 4'(rand_bits(4));
        start_refill(idx);
        push_store(idx, 4'h6, 2'b00, dcache_store_pkg::WRT_WORD, 1'b0);
        push_store(idx, 4'h6, 2'b01, dcache_store_pkg::WRT_BYTE, 1'b0);
        push_store(idx, 4'h6, 2'b10, dcache_store_pkg::WRT_HALF, 1'b0);
        push_store(idx, 4'h6, 2'b11, dcache_store_pkg::WRT_HALF, 1'b0);
        if (st_full !== 1'b1) begin
            $display("FAILED st_full expected %h actual %h", 1'b1, st_full);
            err_count++;
        end
        refill_valid = 1'b0;
        push_store(idx, 4'h6, 2'b00, dcache_store_pkg::WRT_BYTE, 1'b0);
        wait_idle_and_check();
        report_test("full_queue", e0);
    endtask

    task automatic axi_we_test();
        int         e0;
        logic [3:0] last_we;
        logic [3:0] exp_we;
        e0      = err_count;
        last_we = 4'h0;
        exp_we  = lane_mask(dcache_store_pkg::WRT_BYTE, 2'b10, 1'b0);
        push_store(4'ha, 4'h2, 2'b10, dcache_store_pkg::WRT_BYTE, 1'b0);
        // the last busy cycle is the one in which the buffer is written.
        while (!wr_idle) begin
            last_we = axi_we;
            @(negedge clk);
        end
        if (last_we !== exp_we) begin
            $display("FAILED axi_we expected %h actual %h", exp_we, last_we);
            err_count++;
        end
        wait_idle_and_check();
        report_test("axi_we", e0);
    endtask

    initial begin
        rst_n        = 1'b0;
        st_valid     = 1'b0;
        st_addr      = '0;
        st_data      = '0;
        st_type      = '0;
        st_cacop     = 1'b0;
        refill_valid = 1'b0;
        refill_addr  = '0;
        refill_line  = '0;
        rd_en        = 1'b0;
        rd_index     = '0;
        lfsr_state   = 32'd69;
        for (int i = 0; i < dcache_geom_pkg::LINE_COUNT; i++) model[i] = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        word_store_test();
        partial_store_test();
        refill_merge_test();
        cacop_test();
        full_queue_test();
        axi_we_test();
        $display("tests passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 pass_count, fail_count, err_count, dut.u_sva.assert_fails);
        if (err_count == 0 && fail_count == 0 && dut.u_sva.assert_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dcache_wr_path.f */
source/dcache_geom_pkg.sv
source/dcache_store_pkg.sv
source/store_queue.sv
source/refill_store_arb.sv
source/mem_wrt_ctrl_d.sv
source/data_line_ram.sv
source/dcache_wr_path.sv
bench/dcache_wr_path_sva.sv
bench/dcache_wr_path_tb.sv
